// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) hw/soc_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_soc_periph.sv ====
`timescale 1ns/10ps
`include "soc_defines.svh"

module tb_soc_periph import soc_pkg::*; ();

  localparam int TIMEOUT = 200;
  localparam logic [31:0] RAND_BASE = `SOC_SRAM_BASE + 32'h200;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_TICK, OP_DRAIN} op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    axi_resp_e   exp_resp;
  } vec_t;

  logic       clk;
  logic       rst;
  axi_ar_t    ar_i;
  logic       ar_valid_i;
  logic       ar_ready_o;
  axi_r_t     r_o;
  logic       r_valid_o;
  logic       r_ready_i;
  axi_aw_t    aw_i;
  logic       aw_valid_i;
  logic       aw_ready_o;
  axi_w_t     w_i;
  logic       w_valid_i;
  logic       w_ready_o;
  axi_resp_e  b_resp_o;
  logic       b_valid_o;
  logic       b_ready_i;
  logic [7:0] tx_data_o;
  logic       tx_valid_o;
  logic       tx_ready_i;

  vec_t        tbl [$];
  logic [7:0]  exp_bytes [$];
  logic [7:0]  exp_byte;
  logic [31:0] rng;
  logic [31:0] tx_rng;
  logic [31:0] last_tick;
  logic        have_tick;
  logic        timed_out;
  int          checks;
  int          errors;

  soc_periph_top uut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ##################################################
  // compare tasks.
  // ##################################################
  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("TIMEOUT at %0t: %s", $time, what);
  endtask

  // ##################################################
  // manager driver.
  // ##################################################
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output axi_resp_e resp);
    int        n;
    int        hold;
    axi_resp_e first;
    resp = DECERR;
    @(posedge clk);
    #1;
    aw_i.addr  = addr;
    w_i.data   = data;
    w_i.strb   = strb;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!(aw_ready_o && w_ready_o) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!(aw_ready_o && w_ready_o)) begin
      note_timeout($sformatf("write to %h was never accepted", addr));
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
      return;
    end
    // the byte goes out only after this handshake.
    if (addr == `SOC_UART_BASE && strb[0]) begin
      exp_bytes.push_back(data[7:0]);
    end
    @(posedge clk);
    #1;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!b_valid_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!b_valid_o) begin
      note_timeout($sformatf("no write response for %h", addr));
      return;
    end
    first = b_resp_o;
    rng = xorshift(rng);
    hold = int'(rng[2:0]);
    repeat (hold) begin
      @(negedge clk);
      if (!b_valid_o) begin
        errors++;
        $display("ERROR at %0t: b_valid_o fell before b_ready_i was raised", $time);
      end
      check_resp("b_resp_o", first, b_resp_o);
    end
    @(posedge clk);
    #1;
    b_ready_i = 1'b1;
    @(posedge clk);
    #1;
    b_ready_i = 1'b0;
    resp = first;
  endtask

  task automatic axi_read(input logic [31:0] addr, output axi_r_t rsp);
    int     n;
    int     hold;
    axi_r_t first;
    rsp = '0;
    @(posedge clk);
    #1;
    ar_i.addr  = addr;
    ar_valid_i = 1'b1;
    n = 0;
    @(negedge clk);
    while (!ar_ready_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ar_ready_o) begin
      note_timeout($sformatf("read of %h was never accepted", addr));
      ar_valid_i = 1'b0;
      return;
    end
    @(posedge clk);
    #1;
    ar_valid_i = 1'b0;
    n = 0;
    @(negedge clk);
    while (!r_valid_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!r_valid_o) begin
      note_timeout($sformatf("no read response for %h", addr));
      return;
    end
    // data and response must not move while r_ready_i is low.
    first = r_o;
    rng = xorshift(rng);
    hold = int'(rng[2:0]);
    repeat (hold) begin
      @(negedge clk);
      if (!r_valid_o) begin
        errors++;
        $display("ERROR at %0t: r_valid_o fell before r_ready_i was raised", $time);
      end
      check_data("r_o.data", first.data, r_o.data);
      check_resp("r_o.resp", first.resp, r_o.resp);
    end
    @(posedge clk);
    #1;
    r_ready_i = 1'b1;
    @(posedge clk);
    #1;
    r_ready_i = 1'b0;
    rsp = first;
  endtask

  // ##################################################
  // UART sink.
  // ##################################################
  initial begin
    tx_ready_i = 1'b0;
    tx_rng = 32'h700d;
    forever begin
      @(posedge clk);
      #1;
      tx_rng = xorshift(tx_rng);
      tx_ready_i = (tx_rng[1:0] != 2'd0);
    end
  end

  always @(negedge clk) begin
    if (!rst && tx_valid_o && tx_ready_i) begin
      if (exp_bytes.size() == 0) begin
        errors++;
        $display("ERROR at %0t: UART sent byte %h with no write pending", $time, tx_data_o);
      end else begin
        exp_byte = exp_bytes.pop_front();
        check_byte("tx_data_o", exp_byte, tx_data_o);
      end
    end
  end

  task automatic wait_uart_drain();
    int n;
    n = 0;
    while (exp_bytes.size() != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_bytes.size() != 0) begin
      note_timeout($sformatf("%0d UART bytes were never sent", exp_bytes.size()));
    end
  endtask

  // ##################################################
  // stimulus table.
  // ##################################################
  task automatic add_vec(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [31:0] exp_data,
                         input axi_resp_e exp_resp);
    tbl.push_back('{op, addr, data, strb, exp_data, exp_resp});
  endtask

  task automatic build_table();
    // sram writes with full then partial strobes.
    add_vec(OP_WR, `SOC_SRAM_BASE, 32'h1122_3344, 4'hf, 32'h0, OKAY);
    add_vec(OP_RD, `SOC_SRAM_BASE, 32'h0, 4'h0, 32'h1122_3344, OKAY);
    add_vec(OP_WR, `SOC_SRAM_BASE, 32'haabb_ccdd, 4'h5, 32'h0, OKAY);
    add_vec(OP_RD, `SOC_SRAM_BASE, 32'h0, 4'h0, 32'h11bb_33dd, OKAY);
    add_vec(OP_WR, `SOC_SRAM_BASE + 32'hffc, 32'hdead_beef, 4'hf, 32'h0, OKAY);
    add_vec(OP_WR, `SOC_SRAM_BASE + 32'hffc, 32'h0000_cafe, 4'h3, 32'h0, OKAY);
    add_vec(OP_RD, `SOC_SRAM_BASE + 32'hffc, 32'h0, 4'h0, 32'hdead_cafe, OKAY);
    // the uart write with strobe 2 sends nothing.
    add_vec(OP_WR, `SOC_UART_BASE, 32'h0000_0048, 4'h1, 32'h0, OKAY);
    add_vec(OP_WR, `SOC_UART_BASE, 32'hffff_ff69, 4'hf, 32'h0, OKAY);
    add_vec(OP_WR, `SOC_UART_BASE, 32'h0000_5a00, 4'h2, 32'h0, OKAY);
    add_vec(OP_WR, `SOC_UART_BASE, 32'h1234_5621, 4'h1, 32'h0, OKAY);
    add_vec(OP_WR, `SOC_UART_BASE, 32'h0000_000a, 4'h1, 32'h0, OKAY);
    add_vec(OP_DRAIN, 32'h0, 32'h0, 4'h0, 32'h0, OKAY);
    add_vec(OP_RD, `SOC_UART_BASE, 32'h0, 4'h0, 32'h1, OKAY);
    // timer.
    add_vec(OP_TICK, `SOC_RTC_LO, 32'h0, 4'h0, 32'h0, OKAY);
    add_vec(OP_TICK, `SOC_RTC_LO, 32'h0, 4'h0, 32'h0, OKAY);
    add_vec(OP_RD, `SOC_RTC_HI, 32'h0, 4'h0, 32'h0, OKAY);
    add_vec(OP_WR, `SOC_RTC_LO, 32'hffff_ffff, 4'hf, 32'h0, OKAY);
    add_vec(OP_TICK, `SOC_RTC_LO, 32'h0, 4'h0, 32'h0, OKAY);
    add_vec(OP_RD, 32'ha000_0040, 32'h0, 4'h0, 32'h0, OKAY);
    // unmapped space.
    add_vec(OP_RD, 32'h1000_0000, 32'h0, 4'h0, 32'h0, DECERR);
    add_vec(OP_WR, 32'h1000_0000, 32'h5555_5555, 4'hf, 32'h0, DECERR);
    add_vec(OP_RD, `SOC_SRAM_BASE + 32'h1000, 32'h0, 4'h0, 32'h0, DECERR);
    add_vec(OP_WR, 32'hc000_0000, 32'h0, 4'hf, 32'h0, DECERR);
    add_vec(OP_RD, `SOC_SRAM_BASE, 32'h0, 4'h0, 32'h11bb_33dd, OKAY);
  endtask

  task automatic run_vec(input vec_t v);
    axi_resp_e resp;
    axi_r_t    rsp;
    case (v.op)
      OP_WR: begin
        axi_write(v.addr, v.data, v.strb, resp);
        check_resp("b_resp_o", v.exp_resp, resp);
      end
      OP_RD: begin
        axi_read(v.addr, rsp);
        check_data("r_o.data", v.exp_data, rsp.data);
        check_resp("r_o.resp", v.exp_resp, rsp.resp);
      end
      OP_TICK: begin
        axi_read(v.addr, rsp);
        check_resp("r_o.resp", v.exp_resp, rsp.resp);
        if (have_tick && !(rsp.data > last_tick)) begin
          errors++;
          $display("ERROR at %0t: mtime low word went from %h to %h", $time, last_tick, rsp.data);
        end
        last_tick = rsp.data;
        have_tick = 1'b1;
      end
      default: wait_uart_drain();
    endcase
  endtask

  // random strobed writes and reads against a byte model.
  task automatic random_sram();
    logic [31:0] model [8];
    logic [31:0] data;
    logic [3:0]  strb;
    int          idx;
    axi_resp_e   resp;
    axi_r_t      rsp;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      data = rng;
      model[i] = data;
      axi_write(RAND_BASE + 32'(4 * i), data, 4'hf, resp);
      check_resp("b_resp_o", OKAY, resp);
    end
    for (int k = 0; k < 40 && !timed_out; k++) begin
      rng = xorshift(rng);
      idx = int'(rng[2:0]);
      if (rng[3]) begin
        strb = rng[7:4];
        rng = xorshift(rng);
        data = rng;
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            model[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
        axi_write(RAND_BASE + 32'(4 * idx), data, strb, resp);
        check_resp("b_resp_o", OKAY, resp);
      end else begin
        axi_read(RAND_BASE + 32'(4 * idx), rsp);
        check_data("r_o.data", model[idx], rsp.data);
        check_resp("r_o.resp", OKAY, rsp.resp);
      end
    end
  endtask

  // ##################################################
  // main sequence.
  // ##################################################
  initial begin
    rst        = 1'b1;
    ar_i       = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    aw_i       = '0;
    aw_valid_i = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b0;
    rng        = 32'h700d;
    last_tick  = 32'h0;
    have_tick  = 1'b0;
    timed_out  = 1'b0;
    checks     = 0;
    errors     = 0;
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < tbl.size() && !timed_out; i++) begin
      run_vec(tbl[i]);
    end
    if (!timed_out) begin
      random_sram();
    end
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/soc_pkg.sv
hw/lfsr_stall.sv
hw/sram_dev.sv
hw/uart_dev.sv
hw/clint_dev.sv
hw/axi_xbar.sv
hw/soc_periph_top.sv
bench/tb_soc_periph.sv

// ==== hw/axi_xbar.sv ====
`timescale 1ns/10ps
`include "soc_defines.svh"

module axi_xbar import soc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // manager side.
  input  axi_ar_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  input  axi_aw_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output axi_resp_e b_resp_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  // sram side.
  output axi_ar_t   sram_ar_o,
  output logic      sram_ar_valid_o,
  input  logic      sram_ar_ready_i,
  input  axi_r_t    sram_r_i,
  input  logic      sram_r_valid_i,
  output logic      sram_r_ready_o,
  output axi_aw_t   sram_aw_o,
  output logic      sram_aw_valid_o,
  input  logic      sram_aw_ready_i,
  output axi_w_t    sram_w_o,
  output logic      sram_w_valid_o,
  input  logic      sram_w_ready_i,
  input  axi_resp_e sram_b_resp_i,
  input  logic      sram_b_valid_i,
  output logic      sram_b_ready_o,
  // uart side.
  output axi_ar_t   uart_ar_o,
  output logic      uart_ar_valid_o,
  input  logic      uart_ar_ready_i,
  input  axi_r_t    uart_r_i,
  input  logic      uart_r_valid_i,
  output logic      uart_r_ready_o,
  output axi_aw_t   uart_aw_o,
  output logic      uart_aw_valid_o,
  input  logic      uart_aw_ready_i,
  output axi_w_t    uart_w_o,
  output logic      uart_w_valid_o,
  input  logic      uart_w_ready_i,
  input  axi_resp_e uart_b_resp_i,
  input  logic      uart_b_valid_i,
  output logic      uart_b_ready_o,
  // clint side.
  output axi_ar_t   clint_ar_o,
  output logic      clint_ar_valid_o,
  input  logic      clint_ar_ready_i,
  input  axi_r_t    clint_r_i,
  input  logic      clint_r_valid_i,
  output logic      clint_r_ready_o,
  output axi_aw_t   clint_aw_o,
  output logic      clint_aw_valid_o,
  input  logic      clint_aw_ready_i,
  output axi_w_t    clint_w_o,
  output logic      clint_w_valid_o,
  input  logic      clint_w_ready_i,
  input  axi_resp_e clint_b_resp_i,
  input  logic      clint_b_valid_i,
  output logic      clint_b_ready_o
);

  localparam logic [31:0] SRAM_END  = `SOC_SRAM_BASE + 32'(4 * `SOC_SRAM_WORDS);
  localparam logic [28:0] UART_WIN  = 29'(`SOC_UART_BASE >> 3);
  localparam logic [27:0] CLINT_WIN = 28'(`SOC_RTC_LO >> 4);

  xbar_tgt_e ar_tgt;
  xbar_tgt_e aw_tgt;
  xbar_tgt_e rd_tgt;
  xbar_tgt_e wr_tgt;
  logic      rd_busy;
  logic      wr_busy;

  function automatic xbar_tgt_e decode(input logic [31:0] addr);
    xbar_tgt_e tgt;
    tgt = TGT_NONE;
    if (addr >= `SOC_SRAM_BASE && addr < SRAM_END) begin
      tgt = TGT_SRAM;
    end else if (addr[31:3] == UART_WIN) begin
      tgt = TGT_UART;
    end else if (addr[31:4] == CLINT_WIN) begin
      tgt = TGT_CLINT;
    end
    return tgt;
  endfunction

  assign ar_tgt = decode(ar_i.addr);
  assign aw_tgt = decode(aw_i.addr);

  // ##################################################
  // read path.
  // ##################################################
  assign sram_ar_o  = ar_i;
  assign uart_ar_o  = ar_i;
  assign clint_ar_o = ar_i;

  assign sram_ar_valid_o  = ar_valid_i & ~rd_busy & (ar_tgt == TGT_SRAM);
  assign uart_ar_valid_o  = ar_valid_i & ~rd_busy & (ar_tgt == TGT_UART);
  assign clint_ar_valid_o = ar_valid_i & ~rd_busy & (ar_tgt == TGT_CLINT);

  assign sram_r_ready_o  = r_ready_i & rd_busy & (rd_tgt == TGT_SRAM);
  assign uart_r_ready_o  = r_ready_i & rd_busy & (rd_tgt == TGT_UART);
  assign clint_r_ready_o = r_ready_i & rd_busy & (rd_tgt == TGT_CLINT);

  always_comb begin
    case (ar_tgt)
      TGT_SRAM:  ar_ready_o = sram_ar_ready_i;
      TGT_UART:  ar_ready_o = uart_ar_ready_i;
      TGT_CLINT: ar_ready_o = clint_ar_ready_i;
      default:   ar_ready_o = ar_valid_i & ~rd_busy;
    endcase
  end

  // unmapped reads answer DECERR with zero data.
  always_comb begin
    r_o       = '{data: 32'd0, resp: DECERR};
    r_valid_o = 1'b0;
    case (rd_tgt)
      TGT_SRAM: begin
        r_o       = sram_r_i;
        r_valid_o = sram_r_valid_i;
      end
      TGT_UART: begin
        r_o       = uart_r_i;
        r_valid_o = uart_r_valid_i;
      end
      TGT_CLINT: begin
        r_o       = clint_r_i;
        r_valid_o = clint_r_valid_i;
      end
      default: r_valid_o = rd_busy;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_busy <= 1'b0;
      rd_tgt  <= TGT_NONE;
    end else if (ar_valid_i & ar_ready_o) begin
      rd_busy <= 1'b1;
      rd_tgt  <= ar_tgt;
    end else if (r_valid_o & r_ready_i) begin
      rd_busy <= 1'b0;
    end
  end

  // ##################################################
  // write path.
  // ##################################################
  assign sram_aw_o  = aw_i;
  assign uart_aw_o  = aw_i;
  assign clint_aw_o = aw_i;
  assign sram_w_o   = w_i;
  assign uart_w_o   = w_i;
  assign clint_w_o  = w_i;

  // W carries no address and follows the AW decode.
  assign sram_aw_valid_o  = aw_valid_i & ~wr_busy & (aw_tgt == TGT_SRAM);
  assign uart_aw_valid_o  = aw_valid_i & ~wr_busy & (aw_tgt == TGT_UART);
  assign clint_aw_valid_o = aw_valid_i & ~wr_busy & (aw_tgt == TGT_CLINT);
  assign sram_w_valid_o   = w_valid_i & ~wr_busy & (aw_tgt == TGT_SRAM);
  assign uart_w_valid_o   = w_valid_i & ~wr_busy & (aw_tgt == TGT_UART);
  assign clint_w_valid_o  = w_valid_i & ~wr_busy & (aw_tgt == TGT_CLINT);

  assign sram_b_ready_o  = b_ready_i & wr_busy & (wr_tgt == TGT_SRAM);
  assign uart_b_ready_o  = b_ready_i & wr_busy & (wr_tgt == TGT_UART);
  assign clint_b_ready_o = b_ready_i & wr_busy & (wr_tgt == TGT_CLINT);

  always_comb begin
    case (aw_tgt)
      TGT_SRAM: begin
        aw_ready_o = sram_aw_ready_i;
        w_ready_o  = sram_w_ready_i;
      end
      TGT_UART: begin
        aw_ready_o = uart_aw_ready_i;
        w_ready_o  = uart_w_ready_i;
      end
      TGT_CLINT: begin
        aw_ready_o = clint_aw_ready_i;
        w_ready_o  = clint_w_ready_i;
      end
      default: begin
        aw_ready_o = aw_valid_i & w_valid_i & ~wr_busy;
        w_ready_o  = aw_valid_i & w_valid_i & ~wr_busy;
      end
    endcase
  end

  always_comb begin
    b_resp_o  = DECERR;
    b_valid_o = 1'b0;
    case (wr_tgt)
      TGT_SRAM: begin
        b_resp_o  = sram_b_resp_i;
        b_valid_o = sram_b_valid_i;
      end
      TGT_UART: begin
        b_resp_o  = uart_b_resp_i;
        b_valid_o = uart_b_valid_i;
      end
      TGT_CLINT: begin
        b_resp_o  = clint_b_resp_i;
        b_valid_o = clint_b_valid_i;
      end
      default: b_valid_o = wr_busy;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_busy <= 1'b0;
      wr_tgt  <= TGT_NONE;
    end else if (aw_valid_i & aw_ready_o) begin
      wr_busy <= 1'b1;
      wr_tgt  <= aw_tgt;
    end else if (b_valid_o & b_ready_i) begin
      wr_busy <= 1'b0;
    end
  end

endmodule

// ==== hw/clint_dev.sv ====
`timescale 1ns/10ps
`include "soc_defines.svh"

module clint_dev import soc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  axi_ar_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  input  axi_aw_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output axi_resp_e b_resp_o,
  output logic      b_valid_o,
  input  logic      b_ready_i
);

  logic        grant;
  logic [63:0] mtime;

  lfsr_stall u_stall (
    .clk,
    .rst,
    .grant_o(grant)
  );

  assign ar_ready_o = ar_valid_i & grant & ~r_valid_o;
  // mtime is read-only, so writes are acknowledged and dropped.
  assign aw_ready_o = aw_valid_i & w_valid_i & grant & ~b_valid_o;
  assign w_ready_o  = aw_ready_o;
  assign b_resp_o   = OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime     <= 64'd0;
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (ar_ready_o) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
      if (aw_ready_o) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_ready_o) begin
      r_o.resp <= OKAY;
      case (ar_i.addr)
        `SOC_RTC_LO: r_o.data <= mtime[31:0];
        `SOC_RTC_HI: r_o.data <= mtime[63:32];
        default:     r_o.data <= 32'd0;
      endcase
    end
  end

endmodule

// ==== hw/lfsr_stall.sv ====
`timescale 1ns/10ps
`include "soc_defines.svh"

module lfsr_stall (
  input  logic clk,
  input  logic rst,
  output logic grant_o
);

  logic [19:0] lfsr;

  // fibonacci form, taps 19 and 18.
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= `SOC_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[18]};
    end
  end

  assign grant_o = (`SOC_STALL_EN != 0) ? lfsr[19] : 1'b1;

endmodule

// ==== hw/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ##################################################
// address map.
// ##################################################
`define SOC_SRAM_BASE 32'h8000_0000
`define SOC_SRAM_WORDS 1024
`define SOC_UART_BASE 32'ha000_03f8
`define SOC_RTC_LO 32'ha000_0048
`define SOC_RTC_HI 32'ha000_004c

// ##################################################
// wait-state generation.
// ##################################################
// set to 0 for zero-wait-state devices.
`define SOC_STALL_EN 1
`define SOC_LFSR_SEED 20'd101

`endif

// ==== hw/soc_periph_top.sv ====
`timescale 1ns/10ps

module soc_periph_top import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  axi_ar_t    ar_i,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  output axi_r_t     r_o,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  input  axi_aw_t    aw_i,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  axi_w_t     w_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  output axi_resp_e  b_resp_o,
  output logic       b_valid_o,
  input  logic       b_ready_i,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o,
  input  logic       tx_ready_i
);

  axi_ar_t   sram_ar;
  axi_ar_t   uart_ar;
  axi_ar_t   clint_ar;
  axi_r_t    sram_r;
  axi_r_t    uart_r;
  axi_r_t    clint_r;
  axi_aw_t   sram_aw;
  axi_aw_t   uart_aw;
  axi_aw_t   clint_aw;
  axi_w_t    sram_w;
  axi_w_t    uart_w;
  axi_w_t    clint_w;
  axi_resp_e sram_b_resp;
  axi_resp_e uart_b_resp;
  axi_resp_e clint_b_resp;
  logic      sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic      sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
  logic      sram_b_valid, sram_b_ready;
  logic      uart_ar_valid, uart_ar_ready, uart_r_valid, uart_r_ready;
  logic      uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
  logic      uart_b_valid, uart_b_ready;
  logic      clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
  logic      clint_aw_valid, clint_aw_ready, clint_w_valid, clint_w_ready;
  logic      clint_b_valid, clint_b_ready;

  // ##################################################
  // crossbar.
  // ##################################################
  axi_xbar u_xbar (
    .*,
    .sram_ar_o        (sram_ar),
    .sram_ar_valid_o  (sram_ar_valid),
    .sram_ar_ready_i  (sram_ar_ready),
    .sram_r_i         (sram_r),
    .sram_r_valid_i   (sram_r_valid),
    .sram_r_ready_o   (sram_r_ready),
    .sram_aw_o        (sram_aw),
    .sram_aw_valid_o  (sram_aw_valid),
    .sram_aw_ready_i  (sram_aw_ready),
    .sram_w_o         (sram_w),
    .sram_w_valid_o   (sram_w_valid),
    .sram_w_ready_i   (sram_w_ready),
    .sram_b_resp_i    (sram_b_resp),
    .sram_b_valid_i   (sram_b_valid),
    .sram_b_ready_o   (sram_b_ready),
    .uart_ar_o        (uart_ar),
    .uart_ar_valid_o  (uart_ar_valid),
    .uart_ar_ready_i  (uart_ar_ready),
    .uart_r_i         (uart_r),
    .uart_r_valid_i   (uart_r_valid),
    .uart_r_ready_o   (uart_r_ready),
    .uart_aw_o        (uart_aw),
    .uart_aw_valid_o  (uart_aw_valid),
    .uart_aw_ready_i  (uart_aw_ready),
    .uart_w_o         (uart_w),
    .uart_w_valid_o   (uart_w_valid),
    .uart_w_ready_i   (uart_w_ready),
    .uart_b_resp_i    (uart_b_resp),
    .uart_b_valid_i   (uart_b_valid),
    .uart_b_ready_o   (uart_b_ready),
    .clint_ar_o       (clint_ar),
    .clint_ar_valid_o (clint_ar_valid),
    .clint_ar_ready_i (clint_ar_ready),
    .clint_r_i        (clint_r),
    .clint_r_valid_i  (clint_r_valid),
    .clint_r_ready_o  (clint_r_ready),
    .clint_aw_o       (clint_aw),
    .clint_aw_valid_o (clint_aw_valid),
    .clint_aw_ready_i (clint_aw_ready),
    .clint_w_o        (clint_w),
    .clint_w_valid_o  (clint_w_valid),
    .clint_w_ready_i  (clint_w_ready),
    .clint_b_resp_i   (clint_b_resp),
    .clint_b_valid_i  (clint_b_valid),
    .clint_b_ready_o  (clint_b_ready)
  );

  // ##################################################
  // devices.
  // ##################################################
  sram_dev u_sram (
    .clk,
    .rst,
    .ar_i       (sram_ar),
    .ar_valid_i (sram_ar_valid),
    .ar_ready_o (sram_ar_ready),
    .r_o        (sram_r),
    .r_valid_o  (sram_r_valid),
    .r_ready_i  (sram_r_ready),
    .aw_i       (sram_aw),
    .aw_valid_i (sram_aw_valid),
    .aw_ready_o (sram_aw_ready),
    .w_i        (sram_w),
    .w_valid_i  (sram_w_valid),
    .w_ready_o  (sram_w_ready),
    .b_resp_o   (sram_b_resp),
    .b_valid_o  (sram_b_valid),
    .b_ready_i  (sram_b_ready)
  );

  uart_dev u_uart (
    .clk,
    .rst,
    .ar_i       (uart_ar),
    .ar_valid_i (uart_ar_valid),
    .ar_ready_o (uart_ar_ready),
    .r_o        (uart_r),
    .r_valid_o  (uart_r_valid),
    .r_ready_i  (uart_r_ready),
    .aw_i       (uart_aw),
    .aw_valid_i (uart_aw_valid),
    .aw_ready_o (uart_aw_ready),
    .w_i        (uart_w),
    .w_valid_i  (uart_w_valid),
    .w_ready_o  (uart_w_ready),
    .b_resp_o   (uart_b_resp),
    .b_valid_o  (uart_b_valid),
    .b_ready_i  (uart_b_ready),
    .tx_data_o,
    .tx_valid_o,
    .tx_ready_i
  );

  clint_dev u_clint (
    .clk,
    .rst,
    .ar_i       (clint_ar),
    .ar_valid_i (clint_ar_valid),
    .ar_ready_o (clint_ar_ready),
    .r_o        (clint_r),
    .r_valid_o  (clint_r_valid),
    .r_ready_i  (clint_r_ready),
    .aw_i       (clint_aw),
    .aw_valid_i (clint_aw_valid),
    .aw_ready_o (clint_aw_ready),
    .w_i        (clint_w),
    .w_valid_i  (clint_w_valid),
    .w_ready_o  (clint_w_ready),
    .b_resp_o   (clint_b_resp),
    .b_valid_o  (clint_b_valid),
    .b_ready_i  (clint_b_ready)
  );

endmodule

// ==== hw/soc_pkg.sv ====
package soc_pkg;

  // AXI4-Lite response codes.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // crossbar routing target.
  typedef enum logic [1:0] {
    TGT_SRAM  = 2'd0,
    TGT_UART  = 2'd1,
    TGT_CLINT = 2'd2,
    TGT_NONE  = 2'd3
  } xbar_tgt_e;

  typedef struct packed {
    logic [31:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_w_t;

  typedef struct packed {
    logic [31:0] data;
    axi_resp_e   resp;
  } axi_r_t;

endpackage

// ==== hw/sram_dev.sv ====
`timescale 1ns/10ps
`include "soc_defines.svh"

module sram_dev import soc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  axi_ar_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  input  axi_aw_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output axi_resp_e b_resp_o,
  output logic      b_valid_o,
  input  logic      b_ready_i
);

  localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

  logic [31:0]      mem [`SOC_SRAM_WORDS];
  logic             grant;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  lfsr_stall u_stall (
    .clk,
    .rst,
    .grant_o(grant)
  );

  assign rd_idx = ar_i.addr[IDX_W+1:2];
  assign wr_idx = aw_i.addr[IDX_W+1:2];

  assign ar_ready_o = ar_valid_i & grant & ~r_valid_o;
  // AW and W are taken together.
  assign aw_ready_o = aw_valid_i & w_valid_i & grant & ~b_valid_o;
  assign w_ready_o  = aw_ready_o;
  assign b_resp_o   = OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end else begin
      if (ar_ready_o) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
      if (aw_ready_o) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_ready_o) begin
      r_o.data <= mem[rd_idx];
      r_o.resp <= OKAY;
    end
    // byte lanes merge under the strobe.
    if (aw_ready_o) begin
      for (int i = 0; i < 4; i++) begin
        if (w_i.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= w_i.data[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== hw/uart_dev.sv ====
`timescale 1ns/10ps
`include "soc_defines.svh"

module uart_dev import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  axi_ar_t    ar_i,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  output axi_r_t     r_o,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  input  axi_aw_t    aw_i,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  axi_w_t     w_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  output axi_resp_e  b_resp_o,
  output logic       b_valid_o,
  input  logic       b_ready_i,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o,
  input  logic       tx_ready_i
);

  logic grant;
  logic tx_full;
  logic rd_hit;
  logic wr_hit;

  lfsr_stall u_stall (
    .clk,
    .rst,
    .grant_o(grant)
  );

  // only the data register answers OKAY inside the window.
  assign rd_hit = (ar_i.addr == `SOC_UART_BASE);
  assign wr_hit = (aw_i.addr == `SOC_UART_BASE);

  assign ar_ready_o = ar_valid_i & grant & ~r_valid_o;
  // no new write while a byte is still held.
  assign aw_ready_o = aw_valid_i & w_valid_i & grant & ~b_valid_o & ~tx_full;
  assign w_ready_o  = aw_ready_o;
  assign tx_valid_o = tx_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
      tx_full   <= 1'b0;
    end else begin
      if (ar_ready_o) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
      if (aw_ready_o) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (aw_ready_o & wr_hit & w_i.strb[0]) begin
        tx_full <= 1'b1;
      end else if (tx_ready_i) begin
        tx_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_ready_o) begin
      r_o.data <= {31'd0, rd_hit & ~tx_full};
      r_o.resp <= rd_hit ? OKAY : SLVERR;
    end
    if (aw_ready_o) begin
      b_resp_o <= wr_hit ? OKAY : SLVERR;
      if (wr_hit & w_i.strb[0]) begin
        tx_data_o <= w_i.data[7:0];
      end
    end
  end

endmodule
